/* hdl/check_counters.sv */
// Bad-packet counters for the packet checker events.
// Each event pulse bumps its counter at the next edge; counters saturate
// at all ones and hold zero while clr is high. The outputs are snapshot
// registers that track the counters one cycle behind and freeze while
// pause is high, so a host sees the three counts as one consistent set.

`timescale 1ns/1ps
`default_nettype none

module check_counters import client_pkg::*; (
	input  wire    clk_status,
	input  wire    rst,
	input  wire    bad_term,
	input  wire    bad_serial,
	input  wire    bad_dest,
	input  wire    clr,
	input  wire    pause,
	output count_t bad_term_cnt,
	output count_t bad_serial_cnt,
	output count_t bad_dest_cnt
);

	logic [2:0] events;
	count_t     cnt [3];
	count_t     snap [3];

	// index 0 term, 1 serial, 2 dest
	assign events = {bad_dest, bad_serial, bad_term};

	////////////////////
	// live counters
	////////////////////

	always_ff @(posedge clk_status) begin
		for (int i = 0; i < 3; i++) begin
			if (rst || clr) begin
				cnt[i] <= '0;
			end else if (events[i] && cnt[i] != '1) begin
				cnt[i] <= cnt[i] + 1'b1;
			end
		end
	end

	////////////////////
	// read snapshot
	////////////////////

	// counters keep running underneath a pause
	always_ff @(posedge clk_status) begin
		for (int i = 0; i < 3; i++) begin
			if (rst) begin
				snap[i] <= '0;
			end else if (!pause) begin
				snap[i] <= cnt[i];
			end
		end
	end

	assign bad_term_cnt   = snap[0];
	assign bad_serial_cnt = snap[1];
	assign bad_dest_cnt   = snap[2];

endmodule

`default_nettype wire

/* hdl/client_defs.svh */
// Register map and constant values for the packet client status port.
// Included by the decode, execute and result stages and by the testbench.
// Indices are relative to the 64-word window selected by the address prefix.

`ifndef CLIENT_DEFS_SVH
`define CLIENT_DEFS_SVH

// address bits 15:6 must match this, window at 0x1000-0x103f
`define STATUS_ADDR_PREFIX 10'h040

// register indices inside the window
`define REG_SCRATCH    6'h00
`define REG_ID         6'h01
`define REG_TEMP       6'h06
`define REG_BAD_TERM   6'h08
`define REG_BAD_SERIAL 6'h09
`define REG_BAD_DEST   6'h0A
`define REG_TX_CTRL    6'h10
`define REG_RX_CTRL    6'h11
`define REG_SWAP       6'h12
`define REG_HIGH_THR   6'h13
`define REG_LOW_THR    6'h14
`define REG_LOOP_ERR   6'h15
`define REG_LOOP_RST   6'h16

// ascii "CLNT"
`define CLIENT_ID    32'h434C_4E54
`define DEFAULT_READ 32'h0000_0123

// control reset values
`define TX_CTRL_RESET  4'b0010
`define RX_CTRL_RESET  2'b01
`define HIGH_THR_RESET 16'h0280
`define LOW_THR_RESET  16'h0100

`endif

/* hdl/client_pkg.sv */
// Shared types for the packet client status port.
// Modules pull these in with a wildcard import in their header.

`default_nettype none

package client_pkg;

	// host bus address
	typedef logic [15:0] status_addr_t;

	// word index inside the prefix window
	typedef logic [5:0] reg_index_t;

	// bus data word
	typedef logic [31:0] status_word_t;

	// bad-packet counter
	typedef logic [31:0] count_t;

	// loopback FIFO fill threshold
	typedef logic [15:0] threshold_t;

endpackage

`default_nettype wire

/* hdl/packet_client_status.sv */
// Top level of the packet client status port.
// Connects the decode, execute, counter and result stages. The host
// bus, the checker and loopback event pulses and the temperature
// reading come in here; the control fields go out to the datapath.

`timescale 1ns/1ps
`default_nettype none

module packet_client_status import client_pkg::*; (
	input  wire          clk_status,
	input  wire          rst,
	// host bus
	input  status_addr_t status_addr,
	input  wire          status_read,
	input  wire          status_write,
	input  status_word_t status_writedata,
	output status_word_t status_readdata,
	output wire          status_readdata_valid,
	// events from checker and loopback
	input  wire          bad_term,
	input  wire          bad_serial,
	input  wire          bad_dest,
	input  wire          loop_overflow,
	input  wire          loop_underflow,
	input  wire [7:0]    degrees_f,
	// controls to the datapath
	output wire [3:0]    tx_ctrls,
	output wire [7:0]    swap_ctrls,
	output threshold_t   high_threshold,
	output threshold_t   low_threshold,
	output wire          loop_rst
);

	wire          rd_hit;
	wire          wr_hit;
	reg_index_t   reg_index;
	status_word_t wdata;
	status_word_t scratch;
	wire [1:0]    rx_ctrls;
	wire [1:0]    loop_flags;
	count_t       bad_term_cnt;
	count_t       bad_serial_cnt;
	count_t       bad_dest_cnt;

	status_decode i_decode (
		.clk_status       (clk_status),
		.rst              (rst),
		.status_addr      (status_addr),
		.status_read      (status_read),
		.status_write     (status_write),
		.status_writedata (status_writedata),
		.rd_hit           (rd_hit),
		.wr_hit           (wr_hit),
		.reg_index        (reg_index),
		.wdata            (wdata)
	);

	status_exec i_exec (
		.clk_status     (clk_status),
		.rst            (rst),
		.rd_hit         (rd_hit),
		.wr_hit         (wr_hit),
		.reg_index      (reg_index),
		.wdata          (wdata),
		.loop_overflow  (loop_overflow),
		.loop_underflow (loop_underflow),
		.scratch        (scratch),
		.tx_ctrls       (tx_ctrls),
		.rx_ctrls       (rx_ctrls),
		.swap_ctrls     (swap_ctrls),
		.high_threshold (high_threshold),
		.low_threshold  (low_threshold),
		.loop_flags     (loop_flags),
		.loop_rst       (loop_rst)
	);

	// rx_ctrls bit 0 clears, bit 1 pauses the snapshot
	check_counters i_counters (
		.clk_status     (clk_status),
		.rst            (rst),
		.bad_term       (bad_term),
		.bad_serial     (bad_serial),
		.bad_dest       (bad_dest),
		.clr            (rx_ctrls[0]),
		.pause          (rx_ctrls[1]),
		.bad_term_cnt   (bad_term_cnt),
		.bad_serial_cnt (bad_serial_cnt),
		.bad_dest_cnt   (bad_dest_cnt)
	);

	status_result i_result (
		.clk_status            (clk_status),
		.rst                   (rst),
		.rd_hit                (rd_hit),
		.reg_index             (reg_index),
		.scratch               (scratch),
		.degrees_f             (degrees_f),
		.bad_term_cnt          (bad_term_cnt),
		.bad_serial_cnt        (bad_serial_cnt),
		.bad_dest_cnt          (bad_dest_cnt),
		.tx_ctrls              (tx_ctrls),
		.rx_ctrls              (rx_ctrls),
		.swap_ctrls            (swap_ctrls),
		.high_threshold        (high_threshold),
		.low_threshold         (low_threshold),
		.loop_flags            (loop_flags),
		.loop_rst              (loop_rst),
		.status_readdata       (status_readdata),
		.status_readdata_valid (status_readdata_valid)
	);

endmodule

`default_nettype wire

/* hdl/status_decode.sv */
// Front stage of the status port.
// Registers the host strobes, the low address bits and the write data,
// and qualifies the strobes with the address prefix match, so accesses
// outside the window never reach the later stages.

`timescale 1ns/1ps
`default_nettype none

`include "client_defs.svh"

module status_decode import client_pkg::*; (
	input  wire          clk_status,
	input  wire          rst,
	input  status_addr_t status_addr,
	input  wire          status_read,
	input  wire          status_write,
	input  status_word_t status_writedata,
	output logic         rd_hit,
	output logic         wr_hit,
	output reg_index_t   reg_index,
	output status_word_t wdata
);

	logic prefix_match;

	////////////////////
	// address match
	////////////////////

	// upper ten bits select this client
	assign prefix_match = (status_addr[15:6] == `STATUS_ADDR_PREFIX);

	////////////////////
	// strobe stage
	////////////////////

	always_ff @(posedge clk_status) begin
		if (rst) begin
			rd_hit <= 1'b0;
			wr_hit <= 1'b0;
		end else begin
			// dropped here when outside the window
			rd_hit <= status_read & prefix_match;
			wr_hit <= status_write & prefix_match;
		end
	end

	// index and data ride alongside the hits
	always_ff @(posedge clk_status) begin
		reg_index <= status_addr[5:0];
		wdata     <= status_writedata;
	end

endmodule

`default_nettype wire

/* hdl/status_exec.sv */
// Execute stage of the status port.
// Holds the scratch word and the control registers for the transmit,
// receive and loopback paths, and the sticky loopback error flags.
// Writes land one cycle after the decode stage registers the strobe.
// The flags clear on a read hit of the flag word, on the same edge that
// the result stage captures them, or on a write with bit 2 set.

`timescale 1ns/1ps
`default_nettype none

`include "client_defs.svh"

module status_exec import client_pkg::*; (
	input  wire          clk_status,
	input  wire          rst,
	input  wire          rd_hit,
	input  wire          wr_hit,
	input  reg_index_t   reg_index,
	input  status_word_t wdata,
	input  wire          loop_overflow,
	input  wire          loop_underflow,
	output status_word_t scratch,
	output logic [3:0]   tx_ctrls,
	output logic [1:0]   rx_ctrls,
	output logic [7:0]   swap_ctrls,
	output threshold_t   high_threshold,
	output threshold_t   low_threshold,
	output logic [1:0]   loop_flags,
	output logic         loop_rst
);

	logic err_sel;
	logic err_clr;

	////////////////////
	// scratch
	////////////////////

	always_ff @(posedge clk_status) begin
		if (wr_hit && reg_index == `REG_SCRATCH) begin
			scratch <= wdata;
		end
	end

	////////////////////
	// control registers
	////////////////////

	// each field takes the low bits of the write word
	always_ff @(posedge clk_status) begin
		if (rst) begin
			tx_ctrls       <= `TX_CTRL_RESET;
			rx_ctrls       <= `RX_CTRL_RESET;
			swap_ctrls     <= 8'h00;
			high_threshold <= `HIGH_THR_RESET;
			low_threshold  <= `LOW_THR_RESET;
			loop_rst       <= 1'b0;
		end else if (wr_hit) begin
			case (reg_index)
				`REG_TX_CTRL: begin
					tx_ctrls <= wdata[3:0];
				end
				`REG_RX_CTRL: begin
					rx_ctrls <= wdata[1:0];
				end
				`REG_SWAP: begin
					swap_ctrls <= wdata[7:0];
				end
				`REG_HIGH_THR: begin
					high_threshold <= wdata[15:0];
				end
				`REG_LOW_THR: begin
					low_threshold <= wdata[15:0];
				end
				`REG_LOOP_RST: begin
					loop_rst <= wdata[0];
				end
				default: begin
				end
			endcase
		end
	end

	////////////////////
	// sticky loopback flags
	////////////////////

	assign err_sel = (reg_index == `REG_LOOP_ERR);

	// read of the flag word, or explicit clear through bit 2
	assign err_clr = err_sel & (rd_hit | (wr_hit & wdata[2]));

	// bit 1 overflow, bit 0 underflow
	// a pulse in the clear cycle still sets its flag
	always_ff @(posedge clk_status) begin
		if (rst) begin
			loop_flags <= 2'b00;
		end else begin
			loop_flags <= (loop_flags & {2{~err_clr}}) |
				{loop_overflow, loop_underflow};
		end
	end

endmodule

`default_nettype wire

/* hdl/status_result.sv */
// Result stage of the status port.
// Picks the read word for the registered index and captures it on a
// read hit, giving the host data and a one-cycle valid two edges after
// the read strobe is sampled. Narrow fields are zero-extended and
// unmapped indices return the default read word.

`timescale 1ns/1ps
`default_nettype none

`include "client_defs.svh"

module status_result import client_pkg::*; (
	input  wire          clk_status,
	input  wire          rst,
	input  wire          rd_hit,
	input  reg_index_t   reg_index,
	input  status_word_t scratch,
	input  wire [7:0]    degrees_f,
	input  count_t       bad_term_cnt,
	input  count_t       bad_serial_cnt,
	input  count_t       bad_dest_cnt,
	input  wire [3:0]    tx_ctrls,
	input  wire [1:0]    rx_ctrls,
	input  wire [7:0]    swap_ctrls,
	input  threshold_t   high_threshold,
	input  threshold_t   low_threshold,
	input  wire [1:0]    loop_flags,
	input  wire          loop_rst,
	output status_word_t status_readdata,
	output logic         status_readdata_valid
);

	status_word_t rd_word;

	////////////////////
	// read mux
	////////////////////

	always_comb begin
		case (reg_index)
			`REG_SCRATCH:    rd_word = scratch;
			`REG_ID:         rd_word = `CLIENT_ID;
			`REG_TEMP:       rd_word = {24'h0, degrees_f};
			`REG_BAD_TERM:   rd_word = bad_term_cnt;
			`REG_BAD_SERIAL: rd_word = bad_serial_cnt;
			`REG_BAD_DEST:   rd_word = bad_dest_cnt;
			`REG_TX_CTRL:    rd_word = {28'h0, tx_ctrls};
			`REG_RX_CTRL:    rd_word = {30'h0, rx_ctrls};
			`REG_SWAP:       rd_word = {24'h0, swap_ctrls};
			`REG_HIGH_THR:   rd_word = {16'h0, high_threshold};
			`REG_LOW_THR:    rd_word = {16'h0, low_threshold};
			// flags before this read clears them
			`REG_LOOP_ERR:   rd_word = {30'h0, loop_flags};
			`REG_LOOP_RST:   rd_word = {31'h0, loop_rst};
			default:         rd_word = `DEFAULT_READ;
		endcase
	end

	////////////////////
	// output stage
	////////////////////

	always_ff @(posedge clk_status) begin
		if (rst) begin
			status_readdata_valid <= 1'b0;
		end else begin
			status_readdata_valid <= rd_hit;
		end
	end

	// data holds between reads
	always_ff @(posedge clk_status) begin
		if (rd_hit) begin
			status_readdata <= rd_word;
		end
	end

endmodule

`default_nettype wire

/* list.f */
+incdir+hdl
+incdir+tests
hdl/client_pkg.sv
hdl/status_decode.sv
hdl/status_exec.sv
hdl/check_counters.sv
hdl/status_result.sv
hdl/packet_client_status.sv
tests/tb_packet_client.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the packet client testbench with Verilator.
# Exit status is nonzero when the build, the run or any check fails.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_packet_client

verilator --binary --timing -Wno-fatal --top-module "$TOP" -Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "Something failed" "$LOG"; then
	echo "simulation reported failure"
	exit 1
fi

if ! grep -q "Everything OK" "$LOG"; then
	echo "simulation ended without a result"
	exit 1
fi

exit 0

/* tests/tb_vectors.svh */
// Stimulus table for the packet client testbench.
// Included inside the testbench module, after the register map header.
// Row fields are operation, bus address, write data or event mask, and expected word.
// Event mask bits: 0 term, 1 serial, 2 dest, 3 overflow, 4 underflow.
// A read pair reads addr then addr+1; its data field holds the second expected word.

`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

typedef enum int {op_idle, op_write, op_read, op_read_pair, op_miss, op_pulse, op_port} op_t;

typedef struct packed {
	op_t         op;
	logic [15:0] addr;
	logic [31:0] data;
	logic [31:0] exp_word;
} vector_t;

vector_t vectors[$];

function automatic logic [15:0] reg_addr(input logic [5:0] idx);
	return {`STATUS_ADDR_PREFIX, idx};
endfunction

function automatic void add_row(input op_t op, input logic [15:0] addr,
		input logic [31:0] data, input logic [31:0] exp_word);
	vector_t v;
	v.op = op;
	v.addr = addr;
	v.data = data;
	v.exp_word = exp_word;
	vectors.push_back(v);
endfunction

function automatic void load_vectors(input logic [31:0] scr, input int n, input logic [7:0] temp);
	// reset values, scratch, ID, unmapped index, reads back to back
	add_row(op_port, reg_addr(`REG_TX_CTRL), 0, 32'h2);
	add_row(op_port, reg_addr(`REG_SWAP), 0, 32'h0);
	add_row(op_port, reg_addr(`REG_HIGH_THR), 0, 32'h280);
	add_row(op_port, reg_addr(`REG_LOW_THR), 0, 32'h100);
	add_row(op_port, reg_addr(`REG_LOOP_RST), 0, 32'h0);
	add_row(op_write, reg_addr(`REG_SCRATCH), scr, 0);
	add_row(op_read, reg_addr(`REG_SCRATCH), 0, scr);
	add_row(op_read, reg_addr(`REG_ID), 0, "CLNT");
	add_row(op_read, 16'h1003, 0, 32'h123);
	add_row(op_read_pair, reg_addr(`REG_SCRATCH), "CLNT", scr);
	// control registers take the low bits
	add_row(op_write, reg_addr(`REG_TX_CTRL), 32'hFFFF_FFF5, 0);
	add_row(op_port, reg_addr(`REG_TX_CTRL), 0, 32'h5);
	add_row(op_read, reg_addr(`REG_TX_CTRL), 0, 32'h5);
	add_row(op_write, reg_addr(`REG_SWAP), 32'h1234_56A5, 0);
	add_row(op_port, reg_addr(`REG_SWAP), 0, 32'hA5);
	add_row(op_read, reg_addr(`REG_SWAP), 0, 32'hA5);
	add_row(op_write, reg_addr(`REG_HIGH_THR), 32'hABCD_1234, 0);
	add_row(op_port, reg_addr(`REG_HIGH_THR), 0, 32'h1234);
	add_row(op_read, reg_addr(`REG_HIGH_THR), 0, 32'h1234);
	add_row(op_write, reg_addr(`REG_LOW_THR), 32'h00FF_0055, 0);
	add_row(op_port, reg_addr(`REG_LOW_THR), 0, 32'h55);
	add_row(op_read, reg_addr(`REG_LOW_THR), 0, 32'h55);
	// outside the window
	add_row(op_write, 16'h2000, ~scr, 0);
	add_row(op_miss, 16'h2000, 0, 0);
	add_row(op_miss, 16'h1040, 0, 0);
	add_row(op_read, reg_addr(`REG_SCRATCH), 0, scr);
	// counters, released from clear
	add_row(op_write, reg_addr(`REG_RX_CTRL), 0, 0);
	for (int i = 0; i < n; i++) begin
		add_row(op_pulse, 0, 32'h07, 0);
	end
	add_row(op_read, reg_addr(`REG_BAD_TERM), 0, 32'(n));
	add_row(op_read, reg_addr(`REG_BAD_SERIAL), 0, 32'(n));
	add_row(op_read, reg_addr(`REG_BAD_DEST), 0, 32'(n));
	// paused snapshot holds while counting goes on
	add_row(op_write, reg_addr(`REG_RX_CTRL), 32'h2, 0);
	for (int i = 0; i < 3; i++) begin
		add_row(op_pulse, 0, 32'h07, 0);
	end
	add_row(op_read, reg_addr(`REG_BAD_TERM), 0, 32'(n));
	add_row(op_write, reg_addr(`REG_RX_CTRL), 32'h0, 0);
	add_row(op_read, reg_addr(`REG_BAD_TERM), 0, 32'(n + 3));
	add_row(op_read, reg_addr(`REG_BAD_DEST), 0, 32'(n + 3));
	add_row(op_write, reg_addr(`REG_RX_CTRL), 32'h1, 0);
	// clear goes through the counter and then the snapshot
	add_row(op_idle, 0, 0, 0);
	add_row(op_read, reg_addr(`REG_BAD_TERM), 0, 32'h0);
	add_row(op_read, reg_addr(`REG_RX_CTRL), 0, 32'h1);
	// loopback flags, bit 1 overflow, bit 0 underflow
	add_row(op_pulse, 0, 32'h18, 0);
	add_row(op_idle, 0, 0, 0);
	add_row(op_read, reg_addr(`REG_LOOP_ERR), 0, 32'h3);
	add_row(op_read, reg_addr(`REG_LOOP_ERR), 0, 32'h0);
	add_row(op_pulse, 0, 32'h08, 0);
	add_row(op_write, reg_addr(`REG_LOOP_ERR), 32'h0, 0);
	add_row(op_read, reg_addr(`REG_LOOP_ERR), 0, 32'h2);
	add_row(op_pulse, 0, 32'h10, 0);
	add_row(op_write, reg_addr(`REG_LOOP_ERR), 32'h4, 0);
	add_row(op_read, reg_addr(`REG_LOOP_ERR), 0, 32'h0);
	// temperature and loopback reset
	add_row(op_read, reg_addr(`REG_TEMP), 0, {24'h0, temp});
	add_row(op_write, reg_addr(`REG_LOOP_RST), 32'h1, 0);
	add_row(op_port, reg_addr(`REG_LOOP_RST), 0, 32'h1);
	add_row(op_read, reg_addr(`REG_LOOP_RST), 0, 32'h1);
endfunction

`endif

/* tests/tb_packet_client.sv */
// Testbench for the packet client status port.
// Applies the stimulus table one row per step, a nanosecond after the
// rising edge, and checks read data, valid pulses and control ports.
// Scratch data and the event pulse count are random from a fixed seed.

`timescale 1ns/1ps
`default_nettype none

`include "client_defs.svh"

module tb_packet_client;

	localparam int clk_period = 100;

	logic        clk_status;
	logic        rst;
	logic [15:0] status_addr;
	logic        status_read;
	logic        status_write;
	logic [31:0] status_writedata;
	wire  [31:0] status_readdata;
	wire         status_readdata_valid;
	logic        bad_term;
	logic        bad_serial;
	logic        bad_dest;
	logic        loop_overflow;
	logic        loop_underflow;
	logic [7:0]  degrees_f;
	wire  [3:0]  tx_ctrls;
	wire  [7:0]  swap_ctrls;
	wire  [15:0] high_threshold;
	wire  [15:0] low_threshold;
	wire         loop_rst;

	int errors = 0;
	int checks = 0;
	bit loaded = 1'b0;

`include "tb_vectors.svh"

	packet_client_status i_dut (
		.clk_status            (clk_status),
		.rst                   (rst),
		.status_addr           (status_addr),
		.status_read           (status_read),
		.status_write          (status_write),
		.status_writedata      (status_writedata),
		.status_readdata       (status_readdata),
		.status_readdata_valid (status_readdata_valid),
		.bad_term              (bad_term),
		.bad_serial            (bad_serial),
		.bad_dest              (bad_dest),
		.loop_overflow         (loop_overflow),
		.loop_underflow        (loop_underflow),
		.degrees_f             (degrees_f),
		.tx_ctrls              (tx_ctrls),
		.swap_ctrls            (swap_ctrls),
		.high_threshold        (high_threshold),
		.low_threshold         (low_threshold),
		.loop_rst              (loop_rst)
	);

	initial begin
		clk_status = 1'b0;
		forever #(clk_period / 2) clk_status = ~clk_status;
	end

	////////////////////
	// check helpers
	////////////////////

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, want);
		end
	endtask

	task automatic check_valid(input logic want);
		checks++;
		if (status_readdata_valid !== want) begin
			errors++;
			if (want) begin
				$display("error at %0t: no read valid pulse two cycles after the strobe", $time);
			end else begin
				$display("error at %0t: read valid pulse where none was due", $time);
			end
		end
	endtask

	task automatic check_port(input logic [5:0] idx, input logic [31:0] want);
		case (idx)
			`REG_TX_CTRL:  check_word("tx_ctrls", {28'h0, tx_ctrls}, want);
			`REG_SWAP:     check_word("swap_ctrls", {24'h0, swap_ctrls}, want);
			`REG_HIGH_THR: check_word("high_threshold", {16'h0, high_threshold}, want);
			`REG_LOW_THR:  check_word("low_threshold", {16'h0, low_threshold}, want);
			`REG_LOOP_RST: check_word("loop_rst", {31'h0, loop_rst}, want);
			default: begin
				errors++;
				$display("error: table asks for a control port at unknown index %h", idx);
			end
		endcase
	endtask

	task automatic step();
		@(posedge clk_status);
		#1;
	endtask

	////////////////////
	// row driver
	////////////////////

	task automatic apply_row(input vector_t v);
		case (v.op)
			op_write: begin
				status_addr = v.addr;
				status_writedata = v.data;
				status_write = 1'b1;
				step();
				status_write = 1'b0;
			end
			op_read: begin
				status_addr = v.addr;
				status_read = 1'b1;
				step();
				status_read = 1'b0;
				check_valid(1'b0);
				step();
				check_valid(1'b1);
				check_word("status_readdata", status_readdata, v.exp_word);
			end
			op_read_pair: begin
				status_addr = v.addr;
				status_read = 1'b1;
				step();
				status_addr = v.addr + 16'h1;
				step();
				status_read = 1'b0;
				check_valid(1'b1);
				check_word("status_readdata", status_readdata, v.exp_word);
				step();
				check_valid(1'b1);
				check_word("status_readdata", status_readdata, v.data);
			end
			op_miss: begin
				status_addr = v.addr;
				status_read = 1'b1;
				step();
				status_read = 1'b0;
				repeat (4) begin
					step();
					check_valid(1'b0);
				end
			end
			op_pulse: begin
				{loop_underflow, loop_overflow, bad_dest, bad_serial, bad_term} = v.data[4:0];
				step();
				{loop_underflow, loop_overflow, bad_dest, bad_serial, bad_term} = 5'b0;
			end
			op_port: begin
				check_port(v.addr[5:0], v.exp_word);
			end
			default: begin
			end
		endcase
	endtask

	////////////////////
	// main sequence
	////////////////////

	initial begin : main
		logic [31:0] scratch_word;
		int          n_pulses;
		int          errors_before;
		void'($urandom(77639));
		scratch_word = $urandom;
		n_pulses = 1 + int'($urandom % 6);
		rst = 1'b1;
		status_addr = '0;
		status_read = 1'b0;
		status_write = 1'b0;
		status_writedata = '0;
		{loop_underflow, loop_overflow, bad_dest, bad_serial, bad_term} = 5'b0;
		degrees_f = 8'd190;
		load_vectors(scratch_word, n_pulses, degrees_f);
		loaded = 1'b1;
		repeat (5) @(posedge clk_status);
		#1;
		rst = 1'b0;
		foreach (vectors[i]) begin
			step();
			errors_before = errors;
			apply_row(vectors[i]);
			$display("row %0d %s addr %h: %s", i, vectors[i].op.name(), vectors[i].addr,
				(errors == errors_before) ? "ok" : "FAILED");
		end
		$display("%0d rows, %0d checks, %0d errors", vectors.size(), checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// ten clock periods per row is well above the longest row
	initial begin : watchdog
		wait (loaded);
		#(clk_period * (vectors.size() * 10 + 10));
		$display("error: run timed out before the table finished");
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire
